/* verilog/wire_pkg.sv */
// Default repeater parameters and the credit counter width function

package wire_pkg;

  // --------------------
  // Default geometry
  // --------------------

  // Width of one payload word as it enters and leaves the repeater
  localparam int WORD_W_DEF = 64;

  // Number of lanes the word is split across
  // It has to divide the word width evenly
  localparam int NUM_LANES_DEF = 4;

  // Register stages on each lane, which models the length of the wire
  // A value of zero turns every lane into a plain connection
  localparam int NUM_STAGES_DEF = 3;

  // Entries in the landing FIFO, and so the number of credits at reset
  // Two is the smallest depth the pointer logic supports
  localparam int FIFO_DEPTH_DEF = 4;

  // --------------------
  // Helpers
  // --------------------

  // Bits needed by a counter that must reach the value depth itself
  // This covers both the credit counter and the FIFO occupancy count
  function automatic int credit_w(input int depth);
    return $clog2(depth + 1);
  endfunction

endpackage

/* verilog/lane_delay.sv */
// One lane of valid-next delay stages with enable-gated data registers

module lane_delay #(
  // Slice width carried by this lane
  parameter int Width     = 1,
  // Number of register stages, zero gives a pass-through
  parameter int NumStages = 0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid_next,
  input  logic [Width-1:0] in,
  output logic             out_valid_next,
  output logic [Width-1:0] out
);

  // The valid_next flag runs one cycle ahead of the data it qualifies
  // A flag in stage i therefore tells stage i to capture from stage i-1
  // on the clock edge that ends the same cycle
  // This keeps the flag fanout and the long wire on different cycles

  if (NumStages == 0) begin : gen_passthru

    // No registers on the wire at all
    assign out_valid_next = in_valid_next;
    assign out            = in;

  end else begin : gen_stages

    // Flag chain, cleared on reset so no phantom word appears
    logic [NumStages-1:0] vn_q;

    // Data chain, one slice per stage
    logic [Width-1:0] data_q [NumStages];

    // --------------------
    // Valid-next chain
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vn_q <= '0;
      end else begin
        vn_q[0] <= in_valid_next;
        for (int i = 1; i < NumStages; i++) begin
          vn_q[i] <= vn_q[i-1];
        end
      end
    end

    // --------------------
    // Data chain
    // --------------------

    // Each stage only loads when its own flag says a slice is passing
    // Idle stages keep their old value and do not toggle
    always_ff @(posedge clk) begin
      if (vn_q[0]) begin
        data_q[0] <= in;
      end
      for (int i = 1; i < NumStages; i++) begin
        if (vn_q[i]) begin
          data_q[i] <= data_q[i-1];
        end
      end
    end

    // Last stage drives the far end of the wire
    assign out_valid_next = vn_q[NumStages-1];
    assign out            = data_q[NumStages-1];

  end

endmodule

/* verilog/word_launcher.sv */
// Input handshake, credit counter, return-wire delay and word slicing onto the lanes

module word_launcher import wire_pkg::*; #(
  parameter int WORD_W     = WORD_W_DEF,
  parameter int NUM_LANES  = NUM_LANES_DEF,
  parameter int NUM_STAGES = NUM_STAGES_DEF,
  parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  logic [WORD_W-1:0]    in_data,
  input  logic                 pop,
  output logic                 in_ready,
  output logic [NUM_LANES-1:0] launch_valid_next,
  output logic [WORD_W-1:0]    launch_data
);

  // Bits per lane slice
  localparam int LANE_W = WORD_W / NUM_LANES;

  // Counter width able to hold the full FIFO depth
  localparam int CNT_W = credit_w(FIFO_DEPTH);

  // Free FIFO slots at the far end, as seen from this side
  logic [CNT_W-1:0] credit_cnt;

  // Input handshake fires this cycle
  logic accept;

  // Delayed pop, one credit comes back when it is high
  logic credit_ret;

  // Word captured at acceptance, held until the slices are launched
  logic [WORD_W-1:0] hold_q;

  // --------------------
  // Input handshake
  // --------------------

  // Ready as long as at least one landing slot is still free
  assign in_ready = (credit_cnt != '0);
  assign accept   = in_valid && in_ready;

  // --------------------
  // Return wire
  // --------------------

  // The pop pulse travels back over as many stages as the forward lanes
  if (NUM_STAGES > 0) begin : gen_ret_wire

    logic [NUM_STAGES-1:0] ret_q;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        ret_q <= '0;
      end else begin
        ret_q[0] <= pop;
        for (int i = 1; i < NUM_STAGES; i++) begin
          ret_q[i] <= ret_q[i-1];
        end
      end
    end

    assign credit_ret = ret_q[NUM_STAGES-1];

  end else begin : gen_ret_direct

    // Zero-length wire, the credit is back in the same cycle as the pop
    assign credit_ret = pop;

  end

  // --------------------
  // Credit counter
  // --------------------

  // Starts full and moves by at most one per cycle in either direction
  // A returned credit is usable from the cycle after it arrives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= CNT_W'(FIFO_DEPTH);
    end else begin
      case ({accept, credit_ret})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // --------------------
  // Launch registers
  // --------------------

  // One flag copy per lane so each lane gets its own driver
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      launch_valid_next <= '0;
    end else begin
      launch_valid_next <= {NUM_LANES{accept}};
    end
  end

  // Capture the word on the accepting edge, the producer may change it after
  always_ff @(posedge clk) begin
    if (accept) begin
      hold_q <= in_data;
    end
  end

  // One cycle behind the flags, each lane loads its slice under its own flag
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (launch_valid_next[i]) begin
        launch_data[i*LANE_W +: LANE_W] <= hold_q[i*LANE_W +: LANE_W];
      end
    end
  end

endmodule

/* verilog/word_landing.sv */
// Lane join, landing FIFO, output handshake and the pop pulse back to the launcher

module word_landing import wire_pkg::*; #(
  parameter int WORD_W     = WORD_W_DEF,
  parameter int NUM_LANES  = NUM_LANES_DEF,
  parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NUM_LANES-1:0] land_valid_next,
  input  logic [WORD_W-1:0]    land_data,
  input  logic                 out_ready,
  output logic                 out_valid,
  output logic [WORD_W-1:0]    out_data,
  output logic                 pop
);

  // Occupancy counter width, must reach FIFO_DEPTH
  localparam int CNT_W = credit_w(FIFO_DEPTH);

  // Pointer width for a depth of at least two
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // Lane 0 flag delayed by one cycle so it lines up with the slices
  logic land_valid_q;

  // Write strobe into the FIFO
  logic push;

  // Storage, one full word per entry
  logic [WORD_W-1:0] fifo_mem [FIFO_DEPTH];

  // Circular pointers and the number of stored words
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fifo_cnt;

  // Advance a pointer and wrap at the last entry
  // The depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  // --------------------
  // Lane join
  // --------------------

  // All lanes are launched together and carry the same flag pattern
  // Lane 0 alone decides when the joined word is complete
  // The slices already sit in word order on land_data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      land_valid_q <= 1'b0;
    end else begin
      land_valid_q <= land_valid_next[0];
    end
  end

  assign push = land_valid_q;

  // --------------------
  // FIFO storage
  // --------------------

  // Credits upstream keep the writer from ever seeing a full FIFO
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= land_data;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

  // A push and a pop in the same cycle leave the count unchanged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_cnt <= '0;
    end else begin
      case ({push, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // --------------------
  // Output handshake
  // --------------------

  // Head of the FIFO is shown whenever anything is stored
  assign out_valid = (fifo_cnt != '0);
  assign out_data  = fifo_mem[rd_ptr];

  // Every completed output transfer frees one slot, and that is the pop
  // It goes back to the launcher as a credit
  assign pop = out_valid && out_ready;

endmodule

/* verilog/bus_repeater_top.sv */
// Repeater top level with the launcher, the lane generate loop and the landing

module bus_repeater_top import wire_pkg::*; #(
  parameter int WORD_W     = WORD_W_DEF,
  parameter int NUM_LANES  = NUM_LANES_DEF,
  parameter int NUM_STAGES = NUM_STAGES_DEF,
  parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  logic [WORD_W-1:0] in_data,
  output logic              in_ready,
  output logic              out_valid,
  output logic [WORD_W-1:0] out_data,
  input  logic              out_ready
);

  // Bits carried by each lane
  localparam int LANE_W = WORD_W / NUM_LANES;

  // Near end of the wire, one flag per lane plus the sliced word
  logic [NUM_LANES-1:0] launch_valid_next;
  logic [WORD_W-1:0]    launch_data;

  // Far end of the wire, same layout
  logic [NUM_LANES-1:0] land_valid_next;
  logic [WORD_W-1:0]    land_data;

  // Output transfer pulse, travelling back as a credit
  logic pop;

  // --------------------
  // Launcher
  // --------------------

  word_launcher #(
    .WORD_W     (WORD_W),
    .NUM_LANES  (NUM_LANES),
    .NUM_STAGES (NUM_STAGES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_launcher (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_valid          (in_valid),
    .in_data           (in_data),
    .pop               (pop),
    .in_ready          (in_ready),
    .launch_valid_next (launch_valid_next),
    .launch_data       (launch_data)
  );

  // --------------------
  // Lanes
  // --------------------

  // Lane i carries bits i*LANE_W upward, each with its own flag chain
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lanes
    lane_delay #(
      .Width     (LANE_W),
      .NumStages (NUM_STAGES)
    ) u_lane (
      .clk            (clk),
      .rst_n          (rst_n),
      .in_valid_next  (launch_valid_next[i]),
      .in             (launch_data[i*LANE_W +: LANE_W]),
      .out_valid_next (land_valid_next[i]),
      .out            (land_data[i*LANE_W +: LANE_W])
    );
  end

  // --------------------
  // Landing
  // --------------------

  word_landing #(
    .WORD_W     (WORD_W),
    .NUM_LANES  (NUM_LANES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_landing (
    .clk             (clk),
    .rst_n           (rst_n),
    .land_valid_next (land_valid_next),
    .land_data       (land_data),
    .out_ready       (out_ready),
    .out_valid       (out_valid),
    .out_data        (out_data),
    .pop             (pop)
  );

endmodule

/* verif/bus_repeater_chk.sv */
// Static parameter checks and concurrent assertions on the repeater top level

module bus_repeater_chk import wire_pkg::*; #(
  parameter int WORD_W     = WORD_W_DEF,
  parameter int NUM_LANES  = NUM_LANES_DEF,
  parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            in_ready,
  input logic                            out_valid,
  input logic                            out_ready,
  input logic [WORD_W-1:0]               out_data,
  input logic [NUM_LANES-1:0]            land_valid_next,
  input logic [credit_w(FIFO_DEPTH)-1:0] credit_cnt,
  input logic [credit_w(FIFO_DEPTH)-1:0] fifo_cnt
);

  // Number of assertion failures so far
  int fail_cnt = 0;

  // --------------------
  // Geometry
  // --------------------

  initial begin
    assert (WORD_W % NUM_LANES == 0) else begin
      $error("word width %0d does not split into %0d lanes", WORD_W, NUM_LANES);
      fail_cnt++;
    end
    assert (FIFO_DEPTH >= 2) else begin
      $error("landing FIFO depth %0d is below two", FIFO_DEPTH);
      fail_cnt++;
    end
  end

  // --------------------
  // Running checks
  // --------------------

  // Every lane is launched together, so all far-end flags match lane 0
  a_lanes_agree: assert property (@(posedge clk) disable iff (!rst_n)
    land_valid_next == {NUM_LANES{land_valid_next[0]}})
    else begin
      $error("lane valid_next flags disagree: %b", land_valid_next);
      fail_cnt++;
    end

  // A credit only comes home after its word has left the FIFO
  // Free credits and stored words together can never exceed the depth
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    int'(credit_cnt) + int'(fifo_cnt) <= FIFO_DEPTH)
    else begin
      $error("%0d credits and %0d stored words exceed the FIFO depth",
             credit_cnt, fifo_cnt);
      fail_cnt++;
    end

  // With the landing FIFO full no credit is left, so no word may be taken
  a_full_blocks: assert property (@(posedge clk) disable iff (!rst_n)
    (int'(fifo_cnt) == FIFO_DEPTH) |-> !in_ready)
    else begin
      $error("in_ready is high while the landing FIFO is full");
      fail_cnt++;
    end

  // A stalled output word holds still until the consumer takes it
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else begin
      $error("output word changed or vanished while stalled");
      fail_cnt++;
    end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    int'(fifo_cnt) <= FIFO_DEPTH)
    else begin
      $error("landing FIFO holds %0d words, above its depth", fifo_cnt);
      fail_cnt++;
    end

endmodule

/* verif/bus_repeater_monitor.sv */
// Output checker with the accepted-word queue, the reference function and the error counts

module bus_repeater_monitor import wire_pkg::*; #(
  parameter int WORD_W     = WORD_W_DEF,
  parameter int NUM_STAGES = NUM_STAGES_DEF
) (
  input logic              clk,
  input logic              rst_n,
  input logic              in_valid,
  input logic              in_ready,
  input logic [WORD_W-1:0] in_data,
  input logic              out_valid,
  input logic              out_ready,
  input logic [WORD_W-1:0] out_data
);

  int    err_cnt      = 0;
  int    acc_cnt      = 0;
  int    out_cnt      = 0;
  int    last_latency = 0;
  int    cycle        = 0;
  string test_name    = "none";

  // Accepted words in arrival order, with the cycle each one was taken
  logic [WORD_W-1:0] word_q [$];
  int                cyc_q  [$];

  task automatic set_test(input string name);
    test_name = name;
  endtask

  // Scenario checks from the stimulus side
  task automatic check_num(input string what, input int exp, input int act);
    if (exp != act) begin
      err_cnt++;
      $display("FAIL %s (%s): expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  // The repeater neither alters nor reorders, so the oldest accepted word comes next
  function automatic logic [WORD_W-1:0] expected_next();
    return word_q.pop_front();
  endfunction

  task automatic compare_output();
    logic [WORD_W-1:0] exp;
    int                lat;
    if (word_q.size() == 0) begin
      err_cnt++;
      $display("ERROR %s: a word came out although none was accepted", test_name);
    end else begin
      exp = expected_next();
      lat = cycle - cyc_q.pop_front();
      last_latency = lat;
      if (exp !== out_data) begin
        err_cnt++;
        $display("FAIL %s: expected %h, actual %h", test_name, exp, out_data);
      end
      // Lanes, landing register and FIFO set a floor on the delay
      if (lat < NUM_STAGES + 3) begin
        err_cnt++;
        $display("ERROR %s: a word came out after %0d cycles, sooner than possible",
                 test_name, lat);
      end
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (rst_n) begin
      if (in_valid && in_ready) begin
        word_q.push_back(in_data);
        cyc_q.push_back(cycle);
        acc_cnt++;
      end
      if (out_valid && out_ready) begin
        out_cnt++;
        compare_output();
      end
    end
  end

endmodule

/* verif/bus_repeater_tb.sv */
// Repeater testbench with clock, reset, stimulus for each test, watchdog and closing report

module bus_repeater_tb import wire_pkg::*; ();

  localparam int WORD_W         = WORD_W_DEF;
  localparam int NUM_LANES      = NUM_LANES_DEF;
  localparam int NUM_STAGES     = NUM_STAGES_DEF;
  localparam int FIFO_DEPTH     = FIFO_DEPTH_DEF;
  localparam int STREAM_WORDS   = 200;
  localparam int THROTTLE_WORDS = 300;
  localparam int TOTAL_WORDS    = 1 + STREAM_WORDS + FIFO_DEPTH + THROTTLE_WORDS;

  // Each word gets four times its round trip in cycles, at four time units per cycle
  localparam longint TIMEOUT = longint'(TOTAL_WORDS) * (NUM_STAGES + 3 + FIFO_DEPTH) * 4 * 4;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              in_valid;
  logic [WORD_W-1:0] in_data;
  logic              in_ready;
  logic              out_valid;
  logic [WORD_W-1:0] out_data;
  logic              out_ready;
  int                seed = 32'h7384;
  int                cyc  = 0;

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  bus_repeater_top #(
    .WORD_W     (WORD_W),
    .NUM_LANES  (NUM_LANES),
    .NUM_STAGES (NUM_STAGES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  bus_repeater_monitor #(
    .WORD_W     (WORD_W),
    .NUM_STAGES (NUM_STAGES)
  ) u_monitor (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  bind bus_repeater_top bus_repeater_chk #(
    .WORD_W     (WORD_W),
    .NUM_LANES  (NUM_LANES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_ready        (in_ready),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_data        (out_data),
    .land_valid_next (land_valid_next),
    .credit_cnt      (u_launcher.credit_cnt),
    .fifo_cnt        (u_landing.fifo_cnt)
  );

  // --------------------
  // Helpers
  // --------------------

  // Random word built from 32-bit pieces so any width is covered
  function automatic logic [WORD_W-1:0] rand_word();
    logic [WORD_W+31:0] acc;
    acc = '0;
    for (int i = 0; i < (WORD_W + 31) / 32; i++) begin
      acc = {acc[WORD_W-1:0], 32'($random(seed))};
    end
    return acc[WORD_W-1:0];
  endfunction

  // Wait until every accepted word is out, then for its credit to come home
  task automatic wait_drain();
    @(negedge clk);
    while (u_monitor.out_cnt != u_monitor.acc_cnt) @(negedge clk);
    repeat (NUM_STAGES + 2) @(posedge clk);
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic measure_latency();
    u_monitor.set_test("latency");
    out_ready <= 1'b1;
    in_valid  <= 1'b1;
    in_data   <= rand_word();
    @(posedge clk);
    while (!in_ready) @(posedge clk);
    in_valid <= 1'b0;
    wait_drain();
    u_monitor.check_num("cycles to out_valid", NUM_STAGES + 3, u_monitor.last_latency);
  endtask

  // Back-to-back words paced by the credit loop
  // A word pops NUM_STAGES+3 cycles after acceptance and its credit is usable
  // NUM_STAGES+1 cycles after that
  task automatic stream_words();
    int acc_cyc [STREAM_WORDS];
    int exp_cyc;
    u_monitor.set_test("stream");
    out_ready <= 1'b1;
    for (int k = 0; k < STREAM_WORDS; k++) begin
      in_valid <= 1'b1;
      in_data  <= rand_word();
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      acc_cyc[k] = cyc;
      if (k > 0) begin
        exp_cyc = acc_cyc[k-1] + 1;
        if (k >= FIFO_DEPTH && acc_cyc[k-FIFO_DEPTH] + 2 * NUM_STAGES + 4 > exp_cyc) begin
          exp_cyc = acc_cyc[k-FIFO_DEPTH] + 2 * NUM_STAGES + 4;
        end
        u_monitor.check_num("accept cycle", exp_cyc, acc_cyc[k]);
      end
    end
    in_valid <= 1'b0;
    wait_drain();
  endtask

  task automatic fill_under_backpressure();
    int acc;
    acc = 0;
    u_monitor.set_test("backpressure");
    out_ready <= 1'b0;
    in_valid  <= 1'b1;
    in_data   <= rand_word();
    // Long enough for the credits to run out and every word to land
    for (int c = 0; c < FIFO_DEPTH + 2 * NUM_STAGES + 10; c++) begin
      @(posedge clk);
      if (in_ready) begin
        acc++;
        in_data <= rand_word();
      end
    end
    in_valid <= 1'b0;
    u_monitor.check_num("words accepted", FIFO_DEPTH, acc);
    u_monitor.check_num("in_ready when full", 0, int'(in_ready));
    u_monitor.check_num("out_valid when full", 1, int'(out_valid));
    out_ready <= 1'b1;
    wait_drain();
  endtask

  task automatic throttle_both_sides();
    int   acc;
    int   out_base;
    logic fire;
    acc      = 0;
    out_base = u_monitor.out_cnt;
    u_monitor.set_test("throttle");
    in_valid <= 1'b0;
    while (acc < THROTTLE_WORDS) begin
      @(posedge clk);
      fire = in_valid && in_ready;
      if (fire) begin
        acc++;
      end
      out_ready <= ($random(seed) & 3) != 0;
      // A refused word stays on the bus until it is taken
      if (acc == THROTTLE_WORDS) begin
        in_valid <= 1'b0;
      end else if (fire || !in_valid) begin
        in_valid <= ($random(seed) & 1) != 0;
        in_data  <= rand_word();
      end
    end
    // Keep throttling the output until as many words came out as went in
    @(negedge clk);
    while (u_monitor.out_cnt - out_base < acc) begin
      @(posedge clk);
      out_ready <= ($random(seed) & 3) != 0;
      @(negedge clk);
    end
    // The output stays open a while longer so a stray extra word would show
    @(posedge clk);
    out_ready <= 1'b1;
    repeat (NUM_STAGES + FIFO_DEPTH + 3) @(posedge clk);
    @(negedge clk);
    u_monitor.check_num("words delivered", acc, u_monitor.out_cnt - out_base);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    u_monitor.set_test("reset");
    u_monitor.check_num("in_ready", 1, int'(in_ready));
    u_monitor.check_num("out_valid", 0, int'(out_valid));
    measure_latency();
    stream_words();
    fill_under_backpressure();
    throttle_both_sides();
    $display("Report: %0d check errors, %0d assertion failures, %0d words in, %0d words out",
             u_monitor.err_cnt, DUT.u_chk.fail_cnt, u_monitor.acc_cnt, u_monitor.out_cnt);
    if (u_monitor.err_cnt + DUT.u_chk.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog for a stuck handshake or a lost credit
  initial begin
    #(TIMEOUT);
    $display("ERROR: timeout, the tests did not finish within %0d time units", TIMEOUT);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* all.f */
verilog/wire_pkg.sv
verilog/lane_delay.sv
verilog/word_launcher.sv
verilog/word_landing.sv
verilog/bus_repeater_top.sv
verif/bus_repeater_chk.sv
verif/bus_repeater_monitor.sv
verif/bus_repeater_tb.sv

/* Makefile */
OBJ = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module bus_repeater_tb -f all.f -o sim

run: compile
	@out=$$(./$(OBJ)/sim +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ)
